// ==== source/mem_pkg.sv ====
package mem_pkg;

    // ####################
    // sizes
    // ####################
    localparam int ADDR_WIDTH          = 12;
    localparam int DATA_WIDTH          = 32;
    localparam int VECTOR_LANES        = 16;
    localparam int VECTOR_WIDTH        = VECTOR_LANES * DATA_WIDTH; // 512
    localparam int LANE_SEL_WIDTH      = 4;  // lane offset within a row
    localparam int WIDTH_CODE_WIDTH    = 3;
    localparam int INSTR_ADDR_WIDTH    = 9;  // 512 words
    localparam int DATA_ROW_ADDR_WIDTH = 7;  // 128 rows
    localparam int MAT_WIDTH           = 9 * DATA_WIDTH; // 3x3 result

    // ####################
    // address map
    // ####################
    localparam logic [ADDR_WIDTH-1:0] DATA_MASK      = 12'h800;
    localparam logic [ADDR_WIDTH-1:0] DATA_BASE      = 12'h000;
    localparam logic [ADDR_WIDTH-1:0] TEXT_MASK      = 12'he00;
    localparam logic [ADDR_WIDTH-1:0] TEXT_BASE      = 12'h800; // 800 - 9ff
    localparam logic [ADDR_WIDTH-1:0] IO_ADDR        = 12'ha00;
    localparam logic [ADDR_WIDTH-1:0] INV_START_ADDR = 12'ha02;
    localparam logic [ADDR_WIDTH-1:0] INV_L_ADDR     = 12'ha03;
    localparam logic [ADDR_WIDTH-1:0] INV_U_ADDR     = 12'ha04;

    // access width codes, anything else means a full row
    typedef enum logic [WIDTH_CODE_WIDTH-1:0] {
        W32  = 3'd2,  // 1 lane
        W64  = 3'd3,  // 2 lanes
        W128 = 3'd4,  // 4 lanes
        W256 = 3'd5   // 8 lanes
    } width_e;

    // decoded target of an access
    typedef enum logic [2:0] {
        REGION_DATA,
        REGION_TEXT,
        REGION_IO,
        REGION_INV_START,
        REGION_INV_L,
        REGION_INV_U,
        REGION_NONE
    } region_e;

endpackage

// ==== source/instr_mem.sv ====
`timescale 1ns/100ps

module instr_mem (
    input  logic                                 clk,
    input  logic                                 en,
    input  logic                                 we,
    input  logic [mem_pkg::INSTR_ADDR_WIDTH-1:0] addr,
    input  logic       [mem_pkg::DATA_WIDTH-1:0] wdata,
    output logic       [mem_pkg::DATA_WIDTH-1:0] rdata
);

    logic [mem_pkg::DATA_WIDTH-1:0] mem [0:(1 << mem_pkg::INSTR_ADDR_WIDTH)-1];

    // single port, rdata only moves on an enabled read
    always_ff @(posedge clk) begin
        if (en) begin
            if (we) begin
                mem[addr] <= wdata;
            end else begin
                rdata <= mem[addr];
            end
        end
    end

endmodule

// ==== source/data_mem.sv ====
`timescale 1ns/100ps

module data_mem (
    input  logic                                    clk,
    input  logic                                    en,
    input  logic                                    we,
    input  logic [mem_pkg::DATA_ROW_ADDR_WIDTH-1:0] addr,
    input  logic        [mem_pkg::VECTOR_LANES-1:0] wmask,
    input  logic        [mem_pkg::VECTOR_WIDTH-1:0] wdata,
    output logic        [mem_pkg::VECTOR_WIDTH-1:0] rdata
);

    logic [mem_pkg::VECTOR_WIDTH-1:0] mem [0:(1 << mem_pkg::DATA_ROW_ADDR_WIDTH)-1];

    always_ff @(posedge clk) begin
        if (en) begin
            if (we) begin
                // only masked lanes change
                for (int i = 0; i < mem_pkg::VECTOR_LANES; i++) begin
                    if (wmask[i]) begin
                        mem[addr][i*mem_pkg::DATA_WIDTH +: mem_pkg::DATA_WIDTH] <=
                            wdata[i*mem_pkg::DATA_WIDTH +: mem_pkg::DATA_WIDTH];
                    end
                end
            end else begin
                rdata <= mem[addr]; // whole row
            end
        end
    end

endmodule

// ==== source/memory_controller.sv ====
`timescale 1ns/100ps

module memory_controller (
    input  logic                                    clk,
    input  logic                                    arst_n,
    // access from the request port
    input  logic                                    mem_we,
    input  logic                                    mem_re,
    input  logic          [mem_pkg::ADDR_WIDTH-1:0] mem_addr,
    input  logic    [mem_pkg::WIDTH_CODE_WIDTH-1:0] mem_width,
    input  logic        [mem_pkg::VECTOR_WIDTH-1:0] mem_wdata,
    output logic        [mem_pkg::VECTOR_WIDTH-1:0] mem_rdata,
    // instruction store
    output logic                                    instr_mem_en,
    output logic                                    instr_mem_we,
    output logic    [mem_pkg::INSTR_ADDR_WIDTH-1:0] instr_mem_addr,
    output logic          [mem_pkg::DATA_WIDTH-1:0] instr_mem_wdata,
    input  logic          [mem_pkg::DATA_WIDTH-1:0] instr_mem_rdata,
    // data store
    output logic                                    data_mem_en,
    output logic                                    data_mem_we,
    output logic [mem_pkg::DATA_ROW_ADDR_WIDTH-1:0] data_mem_addr,
    output logic        [mem_pkg::VECTOR_LANES-1:0] data_mem_wmask,
    output logic        [mem_pkg::VECTOR_WIDTH-1:0] data_mem_wdata,
    input  logic        [mem_pkg::VECTOR_WIDTH-1:0] data_mem_rdata,
    // factorization results
    input  logic           [mem_pkg::MAT_WIDTH-1:0] mat_l,
    input  logic           [mem_pkg::MAT_WIDTH-1:0] mat_u,
    // io strobes
    output logic                                    io_valid,
    output logic          [mem_pkg::DATA_WIDTH-1:0] io_data,
    output logic                                    inv_start
);

    mem_pkg::width_e                    width;
    mem_pkg::region_e                   region;
    mem_pkg::region_e                   region_r;
    logic                               access;
    logic [mem_pkg::VECTOR_LANES-1:0]   lane_mask;

    assign width  = mem_pkg::width_e'(mem_width);
    assign access = mem_we || mem_re;

    // ####################
    // decode
    // ####################
    always_comb begin
        if ((mem_addr & mem_pkg::DATA_MASK) == mem_pkg::DATA_BASE)
            region = mem_pkg::REGION_DATA;
        else if ((mem_addr & mem_pkg::TEXT_MASK) == mem_pkg::TEXT_BASE)
            region = mem_pkg::REGION_TEXT;
        else if (mem_addr == mem_pkg::IO_ADDR)
            region = mem_pkg::REGION_IO;
        else if (mem_addr == mem_pkg::INV_START_ADDR)
            region = mem_pkg::REGION_INV_START;
        else if (mem_addr == mem_pkg::INV_L_ADDR)
            region = mem_pkg::REGION_INV_L;
        else if (mem_addr == mem_pkg::INV_U_ADDR)
            region = mem_pkg::REGION_INV_U;
        else
            region = mem_pkg::REGION_NONE;
    end

    always_comb begin
        case (width)
            mem_pkg::W32:  lane_mask = 16'h0001;
            mem_pkg::W64:  lane_mask = 16'h0003;
            mem_pkg::W128: lane_mask = 16'h000f;
            mem_pkg::W256: lane_mask = 16'h00ff;
            default:       lane_mask = 16'hffff; // full row
        endcase
    end

    assign instr_mem_en    = access && (region == mem_pkg::REGION_TEXT);
    assign instr_mem_we    = mem_we;
    assign instr_mem_addr  = mem_addr[mem_pkg::INSTR_ADDR_WIDTH-1:0];
    assign instr_mem_wdata = mem_wdata[mem_pkg::DATA_WIDTH-1:0];

    assign data_mem_en    = access && (region == mem_pkg::REGION_DATA);
    assign data_mem_we    = mem_we;
    assign data_mem_addr  = mem_addr[mem_pkg::LANE_SEL_WIDTH +: mem_pkg::DATA_ROW_ADDR_WIDTH];
    assign data_mem_wmask = lane_mask << mem_addr[mem_pkg::LANE_SEL_WIDTH-1:0]; // top lanes drop
    assign data_mem_wdata = mem_wdata;

    // ####################
    // read return
    // ####################
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            region_r <= mem_pkg::REGION_NONE;
        end else if (access) begin
            region_r <= region;
        end
    end

    always_comb begin
        mem_rdata = '0; // io and unmapped read as zero
        case (region_r)
            mem_pkg::REGION_DATA:  mem_rdata = data_mem_rdata;
            mem_pkg::REGION_TEXT:  mem_rdata[mem_pkg::DATA_WIDTH-1:0] = instr_mem_rdata;
            mem_pkg::REGION_INV_L: mem_rdata[mem_pkg::MAT_WIDTH-1:0] = mat_l;
            mem_pkg::REGION_INV_U: mem_rdata[mem_pkg::MAT_WIDTH-1:0] = mat_u;
            default: ;
        endcase
    end

    // ####################
    // io strobes
    // ####################
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            io_valid  <= 1'b0;
            inv_start <= 1'b0;
        end else begin
            io_valid  <= mem_we && (region == mem_pkg::REGION_IO);
            inv_start <= mem_we && (region == mem_pkg::REGION_INV_START);
        end
    end

    always_ff @(posedge clk) begin
        if (mem_we && (region == mem_pkg::REGION_IO)) begin
            io_data <= mem_wdata[mem_pkg::DATA_WIDTH-1:0];
        end
    end

    // never both stores in one cycle
    assert property (@(posedge clk) disable iff (!arst_n)
        $onehot0({instr_mem_en, data_mem_en}));

    assert property (@(posedge clk) disable iff (!arst_n)
        data_mem_en && data_mem_we |-> data_mem_wmask != '0);

endmodule

// ==== source/mem_request_port.sv ====
`timescale 1ns/100ps

module mem_request_port (
    input  logic                                 clk,
    input  logic                                 arst_n,
    // requests
    input  logic                                 req_valid,
    output logic                                 req_ready,
    input  logic                                 req_we,
    input  logic       [mem_pkg::ADDR_WIDTH-1:0] req_addr,
    input  logic [mem_pkg::WIDTH_CODE_WIDTH-1:0] req_width,
    input  logic     [mem_pkg::VECTOR_WIDTH-1:0] req_wdata,
    // read responses
    output logic                                 rsp_valid,
    input  logic                                 rsp_ready,
    output logic     [mem_pkg::VECTOR_WIDTH-1:0] rsp_rdata,
    // toward the controller
    output logic                                 mem_we,
    output logic                                 mem_re,
    output logic       [mem_pkg::ADDR_WIDTH-1:0] mem_addr,
    output logic [mem_pkg::WIDTH_CODE_WIDTH-1:0] mem_width,
    output logic     [mem_pkg::VECTOR_WIDTH-1:0] mem_wdata,
    input  logic     [mem_pkg::VECTOR_WIDTH-1:0] mem_rdata
);

    logic accept;
    logic rsp_pending;

    // stall only while a response sits untaken
    assign req_ready = !rsp_pending || rsp_ready;
    assign accept    = req_valid && req_ready;

    assign mem_we    = accept && req_we;
    assign mem_re    = accept && !req_we;
    assign mem_addr  = req_addr;
    assign mem_width = req_width;
    assign mem_wdata = req_wdata;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rsp_pending <= 1'b0;
        end else if (mem_re) begin
            rsp_pending <= 1'b1; // back to back reads keep it set
        end else if (rsp_ready) begin
            rsp_pending <= 1'b0;
        end
    end

    assign rsp_valid = rsp_pending;
    assign rsp_rdata = mem_rdata; // memories hold while no access is issued

    // no new read may disturb a held response
    assert property (@(posedge clk) disable iff (!arst_n)
        rsp_valid && !rsp_ready |-> !mem_re);

    // held response keeps its data across the memories and the read mux
    assert property (@(posedge clk) disable iff (!arst_n)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_rdata));

endmodule

// ==== source/vector_mem_subsystem.sv ====
`timescale 1ns/100ps

module vector_mem_subsystem (
    input  logic                                 clk,
    input  logic                                 arst_n,
    // requests
    input  logic                                 req_valid,
    output logic                                 req_ready,
    input  logic                                 req_we,
    input  logic       [mem_pkg::ADDR_WIDTH-1:0] req_addr,
    input  logic [mem_pkg::WIDTH_CODE_WIDTH-1:0] req_width,
    input  logic     [mem_pkg::VECTOR_WIDTH-1:0] req_wdata,
    // read responses
    output logic                                 rsp_valid,
    input  logic                                 rsp_ready,
    output logic     [mem_pkg::VECTOR_WIDTH-1:0] rsp_rdata,
    // factorization engine
    input  logic        [mem_pkg::MAT_WIDTH-1:0] mat_l,
    input  logic        [mem_pkg::MAT_WIDTH-1:0] mat_u,
    output logic                                 inv_start,
    // output word
    output logic                                 io_valid,
    output logic       [mem_pkg::DATA_WIDTH-1:0] io_data
);

    // ####################
    // port to controller
    // ####################
    logic                                    mem_we;
    logic                                    mem_re;
    logic          [mem_pkg::ADDR_WIDTH-1:0] mem_addr;
    logic    [mem_pkg::WIDTH_CODE_WIDTH-1:0] mem_width;
    logic        [mem_pkg::VECTOR_WIDTH-1:0] mem_wdata;
    logic        [mem_pkg::VECTOR_WIDTH-1:0] mem_rdata;

    // ####################
    // controller to stores
    // ####################
    logic                                    instr_mem_en;
    logic                                    instr_mem_we;
    logic    [mem_pkg::INSTR_ADDR_WIDTH-1:0] instr_mem_addr;
    logic          [mem_pkg::DATA_WIDTH-1:0] instr_mem_wdata;
    logic          [mem_pkg::DATA_WIDTH-1:0] instr_mem_rdata;
    logic                                    data_mem_en;
    logic                                    data_mem_we;
    logic [mem_pkg::DATA_ROW_ADDR_WIDTH-1:0] data_mem_addr;
    logic        [mem_pkg::VECTOR_LANES-1:0] data_mem_wmask;
    logic        [mem_pkg::VECTOR_WIDTH-1:0] data_mem_wdata;
    logic        [mem_pkg::VECTOR_WIDTH-1:0] data_mem_rdata;

    mem_request_port u_port (
        .clk       (clk),
        .arst_n    (arst_n),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .req_we    (req_we),
        .req_addr  (req_addr),
        .req_width (req_width),
        .req_wdata (req_wdata),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .rsp_rdata (rsp_rdata),
        .mem_we    (mem_we),
        .mem_re    (mem_re),
        .mem_addr  (mem_addr),
        .mem_width (mem_width),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata)
    );

    memory_controller u_ctrl (
        .clk             (clk),
        .arst_n          (arst_n),
        .mem_we          (mem_we),
        .mem_re          (mem_re),
        .mem_addr        (mem_addr),
        .mem_width       (mem_width),
        .mem_wdata       (mem_wdata),
        .mem_rdata       (mem_rdata),
        .instr_mem_en    (instr_mem_en),
        .instr_mem_we    (instr_mem_we),
        .instr_mem_addr  (instr_mem_addr),
        .instr_mem_wdata (instr_mem_wdata),
        .instr_mem_rdata (instr_mem_rdata),
        .data_mem_en     (data_mem_en),
        .data_mem_we     (data_mem_we),
        .data_mem_addr   (data_mem_addr),
        .data_mem_wmask  (data_mem_wmask),
        .data_mem_wdata  (data_mem_wdata),
        .data_mem_rdata  (data_mem_rdata),
        .mat_l           (mat_l),
        .mat_u           (mat_u),
        .io_valid        (io_valid),
        .io_data         (io_data),
        .inv_start       (inv_start)
    );

    instr_mem u_instr_mem (
        .clk   (clk),
        .en    (instr_mem_en),
        .we    (instr_mem_we),
        .addr  (instr_mem_addr),
        .wdata (instr_mem_wdata),
        .rdata (instr_mem_rdata)
    );

    data_mem u_data_mem (
        .clk   (clk),
        .en    (data_mem_en),
        .we    (data_mem_we),
        .addr  (data_mem_addr),
        .wmask (data_mem_wmask),
        .wdata (data_mem_wdata),
        .rdata (data_mem_rdata)
    );

endmodule

// ==== testbench/tb_vector_mem.sv ====
`timescale 1ns/100ps

module tb_vector_mem;

    localparam int VW      = mem_pkg::VECTOR_WIDTH;
    localparam int TIMEOUT = 50; // cycles per wait

    logic                                 clk;
    logic                                 arst_n;
    logic                                 req_valid;
    logic                                 req_ready;
    logic                                 req_we;
    logic       [mem_pkg::ADDR_WIDTH-1:0] req_addr;
    logic [mem_pkg::WIDTH_CODE_WIDTH-1:0] req_width;
    logic                        [VW-1:0] req_wdata;
    logic                                 rsp_valid;
    logic                                 rsp_ready;
    logic                        [VW-1:0] rsp_rdata;
    logic        [mem_pkg::MAT_WIDTH-1:0] mat_l;
    logic        [mem_pkg::MAT_WIDTH-1:0] mat_u;
    logic                                 inv_start;
    logic                                 io_valid;
    logic       [mem_pkg::DATA_WIDTH-1:0] io_data;

    // reference model of both stores
    logic [VW-1:0] data_model [0:127];
    logic   [31:0] text_model [0:511];
    logic   [31:0] lfsr_state;
    logic   [31:0] io_seen;
    logic          aborted;
    int            err_count;
    int            io_count;
    int            start_count;

    vector_mem_subsystem u_dut (.*);

    always #10 clk = ~clk;

    always @(posedge clk) begin
        if (io_valid) begin
            io_count++;
            io_seen = io_data;
        end
        if (inv_start) start_count++;
    end

    // ####################
    // model helpers
    // ####################
    function automatic logic [31:0] next_lfsr(input logic [31:0] s);
        if (s[0]) return (s >> 1) ^ 32'h80200003; // galois taps 32 22 2 1
        return s >> 1;
    endfunction

    task automatic fill_random(output logic [VW-1:0] v, input int nbits);
        v = '0;
        for (int i = 0; i < nbits; i++) begin
            lfsr_state = next_lfsr(lfsr_state);
            v[i]       = lfsr_state[0];
        end
    endtask

    function automatic mem_pkg::region_e region_of(input logic [11:0] addr);
        if (!addr[11]) return mem_pkg::REGION_DATA;
        if (addr[11:9] == 3'b100) return mem_pkg::REGION_TEXT;
        if (addr == mem_pkg::IO_ADDR) return mem_pkg::REGION_IO;
        if (addr == mem_pkg::INV_START_ADDR) return mem_pkg::REGION_INV_START;
        if (addr == mem_pkg::INV_L_ADDR) return mem_pkg::REGION_INV_L;
        if (addr == mem_pkg::INV_U_ADDR) return mem_pkg::REGION_INV_U;
        return mem_pkg::REGION_NONE;
    endfunction

    function automatic logic [15:0] lane_mask_for(input int width, input logic [3:0] offset);
        logic [31:0] ones;
        int          lanes;
        case (width)
            2:       lanes = 1;
            3:       lanes = 2;
            4:       lanes = 4;
            5:       lanes = 8;
            default: lanes = 16;
        endcase
        ones = ((32'd1 << lanes) - 32'd1) << offset;
        return ones[15:0]; // lanes past 15 fall off
    endfunction

    task automatic apply_write(input logic [11:0] addr, input int width, input logic [VW-1:0] d);
        logic [15:0] mask;
        mask = lane_mask_for(width, addr[3:0]);
        if (region_of(addr) == mem_pkg::REGION_DATA) begin
            for (int i = 0; i < 16; i++) begin
                if (mask[i]) data_model[addr[10:4]][i*32 +: 32] = d[i*32 +: 32];
            end
        end else if (region_of(addr) == mem_pkg::REGION_TEXT) begin
            text_model[addr[8:0]] = d[31:0];
        end
    endtask

    function automatic logic [VW-1:0] expected_read(input logic [11:0] addr);
        logic [VW-1:0] v;
        v = '0;
        case (region_of(addr))
            mem_pkg::REGION_DATA:  v = data_model[addr[10:4]];
            mem_pkg::REGION_TEXT:  v[31:0] = text_model[addr[8:0]];
            mem_pkg::REGION_INV_L: v[mem_pkg::MAT_WIDTH-1:0] = mat_l;
            mem_pkg::REGION_INV_U: v[mem_pkg::MAT_WIDTH-1:0] = mat_u;
            default: ;
        endcase
        return v;
    endfunction

    task automatic report_mismatch(input string name, input logic [VW-1:0] exp,
                                   input logic [VW-1:0] act);
        $display("ERROR at %0t ns: %s expected %0h, got %0h", $time, name, exp, act);
        err_count++;
    endtask

    task automatic report_problem(input string msg);
        $display("problem at %0t ns: %s", $time, msg);
        err_count++;
    endtask

    // ####################
    // bus tasks
    // ####################
    task automatic issue_request(input logic we, input int width, input logic [11:0] addr,
                                 input logic [VW-1:0] d);
        int cycles;
        cycles    = 0;
        req_valid = 1'b1;
        req_we    = we;
        req_width = width[2:0];
        req_addr  = addr;
        req_wdata = d;
        while (!req_ready && cycles < TIMEOUT) begin
            @(posedge clk);
            #2;
            cycles++;
        end
        if (!req_ready) begin
            report_problem("req_ready never came high");
            aborted = 1'b1;
        end else begin
            @(posedge clk); // acceptance edge
            #2;
        end
        req_valid = 1'b0;
    endtask

    task automatic collect_response(input int hold, input logic [VW-1:0] exp);
        logic [VW-1:0] first;
        logic   [11:0] other;
        int            cycles;
        cycles = 0;
        other  = (exp === expected_read(mem_pkg::INV_L_ADDR)) ? mem_pkg::INV_U_ADDR
                                                              : mem_pkg::INV_L_ADDR;
        while (!rsp_valid && cycles < TIMEOUT) begin
            @(posedge clk);
            #2;
            cycles++;
        end
        if (!rsp_valid) begin
            report_problem("no read response arrived");
            aborted = 1'b1;
        end else begin
            first = rsp_rdata;
            if (first !== exp) report_mismatch("rsp_rdata", exp, first);
            if (hold > 0) begin
                // a competing read that must stay blocked
                req_valid = 1'b1;
                req_we    = 1'b0;
                req_width = '0;
                req_addr  = other;
            end
            for (int i = 0; i < hold; i++) begin
                @(posedge clk);
                #2;
                if (!rsp_valid) report_problem("rsp_valid dropped before it was taken");
                if (rsp_rdata !== first) report_mismatch("rsp_rdata held", first, rsp_rdata);
                if (req_ready !== 1'b0) report_mismatch("req_ready", 1'b0, req_ready);
            end
            req_valid = 1'b0;
            rsp_ready = 1'b1;
            #1;
            if (req_ready !== 1'b1) report_mismatch("req_ready", 1'b1, req_ready);
            @(posedge clk);
            #2;
            rsp_ready = 1'b0;
            if (rsp_valid !== 1'b0) report_mismatch("rsp_valid", 1'b0, rsp_valid);
        end
    endtask

    task automatic run_test(input string op, input int width, input logic [11:0] addr,
                            input int hold);
        logic [VW-1:0]    d;
        mem_pkg::region_e region;
        int               io_before;
        int               start_before;
        int               cycles;
        int               io_exp;
        int               start_exp;
        io_before    = io_count;
        start_before = start_count;
        region       = region_of(addr);
        io_exp       = (op == "W" && region == mem_pkg::REGION_IO) ? 1 : 0;
        start_exp    = (op == "W" && region == mem_pkg::REGION_INV_START) ? 1 : 0;
        d            = '0;
        if (op == "W") begin
            fill_random(d, VW);
            issue_request(1'b1, width, addr, d);
            apply_write(addr, width, d);
        end else begin
            issue_request(1'b0, width, addr, '0);
            if (!aborted) collect_response(hold, expected_read(addr));
        end
        cycles = 0;
        while ((io_exp + start_exp) > 0 && io_count == io_before
               && start_count == start_before && cycles < TIMEOUT) begin
            @(posedge clk);
            #2;
            cycles++;
        end
        repeat (2) @(posedge clk); // let any extra pulse show up
        #2;
        if (io_count - io_before != io_exp) report_problem("wrong number of io_valid pulses");
        if (start_count - start_before != start_exp)
            report_problem("wrong number of inv_start pulses");
        if (io_exp == 1 && io_seen !== d[31:0]) report_mismatch("io_data", d[31:0], io_seen);
    endtask

    initial begin
        string         line;
        string         op;
        string         tag;
        logic [VW-1:0] tmp;
        logic   [11:0] addr;
        int            fd;
        int            n;
        int            width;
        int            hold;
        int            errs_before;
        int            tests;
        int            fails;
        clk         = 1'b0;
        arst_n      = 1'b0;
        req_valid   = 1'b0;
        req_we      = 1'b0;
        req_addr    = '0;
        req_width   = '0;
        req_wdata   = '0;
        rsp_ready   = 1'b0;
        aborted     = 1'b0;
        err_count   = 0;
        io_count    = 0;
        start_count = 0;
        tests       = 0;
        fails       = 0;
        lfsr_state  = 32'h6b02e039;
        fill_random(tmp, mem_pkg::MAT_WIDTH);
        mat_l = tmp[mem_pkg::MAT_WIDTH-1:0];
        fill_random(tmp, mem_pkg::MAT_WIDTH);
        mat_u = tmp[mem_pkg::MAT_WIDTH-1:0];
        repeat (16) @(posedge clk);
        #2;
        arst_n = 1'b1;
        #1;
        if (req_ready !== 1'b1) report_mismatch("req_ready", 1'b1, req_ready);
        if (rsp_valid !== 1'b0) report_mismatch("rsp_valid", 1'b0, rsp_valid);
        if (io_valid !== 1'b0) report_mismatch("io_valid", 1'b0, io_valid);
        if (inv_start !== 1'b0) report_mismatch("inv_start", 1'b0, inv_start);
        @(posedge clk);
        #2;
        fd = $fopen("testbench/mem_tests.txt", "r");
        if (fd == 0) report_problem("could not open testbench/mem_tests.txt");
        while (fd != 0 && !$feof(fd) && !aborted) begin
            line = "";
            void'($fgets(line, fd));
            n = $sscanf(line, "%s %d %h %d %s", op, width, addr, hold, tag);
            if (n == 5 && (op == "W" || op == "R")) begin
                errs_before = err_count;
                run_test(op, width, addr, hold);
                tests++;
                if (err_count != errs_before) fails++;
                $display("test %0d %s %s", tests, tag, (err_count != errs_before) ? "FAIL" : "ok");
            end
        end
        if (fd != 0) $fclose(fd);
        $display("tests %0d, passed %0d, failed %0d", tests, tests - fails, fails);
        if (err_count == 0 && !aborted && tests > 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// ==== build.f ====
source/mem_pkg.sv
source/instr_mem.sv
source/data_mem.sv
source/memory_controller.sv
source/mem_request_port.sv
source/vector_mem_subsystem.sv
testbench/tb_vector_mem.sv

// ==== testbench/mem_tests.txt ====
# op width addr hold tag
# op W or R, width code decimal, word address hex, rsp_ready low cycles, tag
W 0 000 0 full_row0
R 0 000 0 rd_row0
W 7 7f0 0 full_row127
R 0 7f0 3 rd_row127_hold
W 6 400 0 full_row64
R 1 400 0 rd_row64
W 0 010 0 full_row1
W 2 015 0 w32_lane5
R 0 010 0 rd_w32
W 3 01e 0 w64_lane14
R 0 010 2 rd_w64
W 4 01f 0 w128_lane15_past_top
R 0 010 0 rd_w128
W 5 019 0 w256_lane9_past_top
R 0 010 1 rd_w256
W 0 800 0 text_low
R 0 800 0 rd_text_low
W 2 9ff 0 text_high
R 0 9ff 4 rd_text_high
W 0 a00 0 io_word
W 0 c00 0 unmapped_c00
R 0 800 0 rd_text_no_alias
R 0 400 0 rd_row64_no_alias
R 0 a00 0 rd_io_zero
W 0 a02 0 inv_start_pulse
R 0 a02 0 rd_start_zero
R 0 a03 2 rd_mat_l
R 0 a04 0 rd_mat_u
R 0 a01 0 rd_unmapped_a01
W 0 fff 0 unmapped_fff
R 0 7f0 0 rd_row127_again
R 0 fff 5 rd_fff_zero
W 0 a00 0 io_word_again
